/* Makefile */
VERILATOR ?= verilator
TOP ?= pipeline_block_tb
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG ?= Done: no errors
SOURCES := $(wildcard design/*.sv verif/*.sv)

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(OBJ_DIR)/V$(TOP)
	@out="$$($(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

/* design/block_alu.sv */
`default_nettype none

module block_alu (
	input  block_pkg::opcode_t op,
	input  block_pkg::data_t   a,
	input  block_pkg::data_t   b,
	output block_pkg::data_t   result
);

	logic signed [block_pkg::DATA_W:0] sum;
	logic signed [block_pkg::DATA_W:0] diff;

	function automatic block_pkg::data_t saturate(input logic signed [block_pkg::DATA_W:0] x);
		if (x > block_pkg::SAT_MAX) begin
			return block_pkg::data_t'(block_pkg::SAT_MAX);
		end else if (x < block_pkg::SAT_MIN) begin
			return block_pkg::data_t'(block_pkg::SAT_MIN);
		end
		return x[block_pkg::DATA_W-1:0];
	endfunction

	// One extra bit so overflow is visible before clamping
	assign sum  = {a[block_pkg::DATA_W-1], a} + {b[block_pkg::DATA_W-1], b};
	assign diff = {a[block_pkg::DATA_W-1], a} - {b[block_pkg::DATA_W-1], b};

	always_comb begin
		case (op)
			block_pkg::OP_ADD: result = saturate(sum);
			block_pkg::OP_SUB: result = saturate(diff);
			block_pkg::OP_ABS: begin
				if (a == block_pkg::data_t'(block_pkg::SAT_MIN)) begin
					result = block_pkg::data_t'(block_pkg::SAT_MAX);
				end else begin
					result = (a < 0) ? -a : a;
				end
			end
			block_pkg::OP_LSH: result = a <<< 1;
			block_pkg::OP_RSH: result = a >>> 1;
			default:           result = a;
		endcase
	end

endmodule

`default_nettype wire

/* design/block_control.sv */
`default_nettype none

module block_control (
	input  logic               clk,
	input  logic               reset,
	input  logic               tick,
	input  block_pkg::instr_t  instr_val,
	input  logic               instr_write,
	operand_if.ctrl            opnd,
	mul_if.ctrl                mul,
	output block_pkg::opcode_t alu_op,
	output block_pkg::data_t   alu_a,
	output block_pkg::data_t   alu_b,
	input  block_pkg::data_t   alu_result,
	output logic               done
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_BEGIN,
		S_WAIT,
		S_STORE
	} state_t;

	state_t             state;
	block_pkg::instr_t  instr;
	block_pkg::opcode_t op;
	block_pkg::data_t   a_q;
	block_pkg::data_t   b_q;
	logic               mul_start_q;
	logic               product_ready;
	logic               single_cycle;

	assign op = block_pkg::opcode_t'(instr[block_pkg::OP_W-1:0]);

	assign opnd.rd_a     = instr[block_pkg::SRC_A_LSB +: block_pkg::ADDR_W];
	assign opnd.rd_b     = instr[block_pkg::SRC_B_LSB +: block_pkg::ADDR_W];
	assign opnd.rd_c     = instr[block_pkg::SRC_C_LSB +: block_pkg::ADDR_W];
	assign opnd.wr_addr  = instr[block_pkg::DEST_LSB +: block_pkg::ADDR_W];
	assign opnd.rd_a_reg = instr[block_pkg::KIND_LSB];
	assign opnd.rd_b_reg = instr[block_pkg::KIND_LSB + 1];
	assign opnd.rd_c_reg = instr[block_pkg::KIND_LSB + 2];
	assign opnd.wr_reg   = instr[block_pkg::KIND_LSB + 3];

	// Latched operands serve both the adder and the multiplier
	assign mul.start = mul_start_q;
	assign mul.a     = a_q;
	assign mul.b     = b_q;
	assign mul.shift = instr[block_pkg::PMS_LSB +: block_pkg::PMS_W];

	// A late pulse from an aborted multiply can only land while start is high
	assign product_ready = mul.done_pulse && !mul.start;

	assign single_cycle = (op == block_pkg::OP_ABS) || (op == block_pkg::OP_LSH) ||
		(op == block_pkg::OP_RSH);

	assign alu_op = (op == block_pkg::OP_MAC) ? block_pkg::OP_ADD : op;
	assign alu_a  = (state == S_BEGIN) ? opnd.val_a : a_q;
	assign alu_b  = (state == S_BEGIN) ? opnd.val_b : b_q;

	// No result is stored in the cycle a tick aborts the instruction
	assign opnd.wr_en = !tick && ((state == S_BEGIN && single_cycle) ||
		(state == S_WAIT && op == block_pkg::OP_MUL && product_ready) ||
		(state == S_STORE));
	assign opnd.wr_data = (state == S_WAIT) ? mul.product : alu_result;

	always_ff @(posedge clk) begin
		if (reset) begin
			instr <= '0;
			state <= S_IDLE;
			done <= 1'b1;
			mul_start_q <= 1'b0;
		end else begin
			mul_start_q <= 1'b0;
			if (instr_write) begin
				instr <= instr_val;
			end

			if (tick) begin
				state <= S_BEGIN;
				done <= 1'b0;
			end else begin
				case (state)
					S_BEGIN: begin
						case (op)
							block_pkg::OP_ADD, block_pkg::OP_SUB: begin
								state <= S_STORE;
							end
							block_pkg::OP_MUL, block_pkg::OP_MAC: begin
								mul_start_q <= 1'b1;
								state <= S_WAIT;
							end
							default: begin
								state <= S_IDLE;
								done <= 1'b1;
							end
						endcase
					end
					S_WAIT: begin
						if (product_ready) begin
							if (op == block_pkg::OP_MAC) begin
								state <= S_STORE;
							end else begin
								state <= S_IDLE;
								done <= 1'b1;
							end
						end
					end
					S_STORE: begin
						state <= S_IDLE;
						done <= 1'b1;
					end
					default: begin
					end
				endcase
			end
		end
	end

	// MAC reuses the adder path with the clamped product and operand c
	always_ff @(posedge clk) begin
		if (state == S_BEGIN) begin
			a_q <= opnd.val_a;
			b_q <= opnd.val_b;
		end else if (state == S_WAIT && product_ready) begin
			a_q <= mul.product;
			b_q <= opnd.val_c;
		end
	end

endmodule

`default_nettype wire

/* design/block_ifs.sv */
`default_nettype none

// Operand reads and result write between control and storage
interface operand_if;
	block_pkg::addr_t rd_a;
	logic             rd_a_reg;
	block_pkg::addr_t rd_b;
	logic             rd_b_reg;
	block_pkg::addr_t rd_c;
	logic             rd_c_reg;
	block_pkg::data_t val_a;
	block_pkg::data_t val_b;
	block_pkg::data_t val_c;
	logic             wr_en;
	logic             wr_reg;
	block_pkg::addr_t wr_addr;
	block_pkg::data_t wr_data;

	modport ctrl (
		output rd_a, rd_a_reg, rd_b, rd_b_reg, rd_c, rd_c_reg,
		output wr_en, wr_reg, wr_addr, wr_data,
		input  val_a, val_b, val_c
	);

	modport store (
		input  rd_a, rd_a_reg, rd_b, rd_b_reg, rd_c, rd_c_reg,
		input  wr_en, wr_reg, wr_addr, wr_data,
		output val_a, val_b, val_c
	);
endinterface

// Multiply request and result
interface mul_if;
	logic                          start;
	block_pkg::data_t              a;
	block_pkg::data_t              b;
	logic [block_pkg::PMS_W-1:0]   shift;
	logic                          busy;
	logic                          done_pulse;
	block_pkg::data_t              product;

	modport ctrl (output start, a, b, shift, input busy, done_pulse, product);
	modport unit (input start, a, b, shift, output busy, done_pulse, product);
endinterface

`default_nettype wire

/* design/block_multiplier.sv */
`default_nettype none

module block_multiplier (
	input logic clk,
	input logic reset,
	mul_if.unit mul
);

	logic signed [block_pkg::PROD_W-1:0] acc;
	logic signed [block_pkg::PROD_W-1:0] mcand;
	logic [block_pkg::DATA_W-1:0]        mplier;
	logic [block_pkg::PMS_W-1:0]         shift_q;
	logic [block_pkg::CNT_W-1:0]         count;
	logic                                last_step;
	logic signed [block_pkg::PROD_W-1:0] scaled;

	// Sign bit of the multiplier carries negative weight
	assign last_step = (int'(count) == block_pkg::DATA_W - 1);

	always_ff @(posedge clk) begin
		if (reset) begin
			mul.busy <= 1'b0;
			mul.done_pulse <= 1'b0;
			count <= '0;
		end else begin
			mul.done_pulse <= 1'b0;
			if (mul.start) begin
				mul.busy <= 1'b1;
				count <= '0;
			end else if (mul.busy) begin
				count <= count + 1'b1;
				if (last_step) begin
					mul.busy <= 1'b0;
					mul.done_pulse <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (mul.start) begin
			acc <= '0;
			mcand <= {{block_pkg::DATA_W{mul.a[block_pkg::DATA_W-1]}}, mul.a};
			mplier <= mul.b;
			shift_q <= mul.shift;
		end else if (mul.busy) begin
			if (mplier[0]) begin
				acc <= last_step ? acc - mcand : acc + mcand;
			end
			mcand <= mcand <<< 1;
			mplier <= mplier >> 1;
		end
	end

	// Back to Q1.15, the shift field moves the binary point left
	assign scaled = acc >>> (block_pkg::MUL_FRAC - int'(shift_q));

	assign mul.product = (scaled > block_pkg::SAT_MAX) ? block_pkg::data_t'(block_pkg::SAT_MAX) :
		(scaled < block_pkg::SAT_MIN) ? block_pkg::data_t'(block_pkg::SAT_MIN) :
		scaled[block_pkg::DATA_W-1:0];

endmodule

`default_nettype wire

/* design/block_pkg.sv */
`default_nettype none

package block_pkg;

	localparam int DATA_W  = 16;
	localparam int N_CH    = 16;
	localparam int N_REG   = 16;
	localparam int ADDR_W  = 4;
	localparam int OP_W    = 4;
	localparam int PMS_W   = 4;
	localparam int INSTR_W = 28;

	// Multiplier sizing
	localparam int PROD_W = 2 * DATA_W;
	localparam int CNT_W  = $clog2(DATA_W);

	// Instruction word layout, opcode in the low bits
	localparam int SRC_A_LSB = OP_W;
	localparam int SRC_B_LSB = SRC_A_LSB + ADDR_W;
	localparam int SRC_C_LSB = SRC_B_LSB + ADDR_W;
	localparam int DEST_LSB  = SRC_C_LSB + ADDR_W;
	localparam int KIND_LSB  = DEST_LSB + ADDR_W;
	localparam int PMS_LSB   = KIND_LSB + 4;

	localparam int SAT_MAX  = 32767;
	localparam int SAT_MIN  = -32768;
	localparam int MUL_FRAC = 15;

	typedef logic signed [DATA_W-1:0] data_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [INSTR_W-1:0] instr_t;

	typedef enum logic [OP_W-1:0] {
		OP_NOP = 4'd0,
		OP_ADD = 4'd1,
		OP_SUB = 4'd2,
		OP_LSH = 4'd3,
		OP_RSH = 4'd4,
		OP_ABS = 4'd5,
		OP_MUL = 4'd6,
		OP_MAC = 4'd7
	} opcode_t;

endpackage

`default_nettype wire

/* design/operand_file.sv */
`default_nettype none

module operand_file (
	input  logic             clk,
	input  logic             reset,
	input  logic             tick,
	input  block_pkg::data_t ch_in [block_pkg::N_CH],
	output block_pkg::data_t ch_out [block_pkg::N_CH],
	input  block_pkg::data_t reg_val,
	input  block_pkg::addr_t reg_target,
	input  logic             reg_write,
	input  logic             reg_update,
	operand_if.store         opnd
);

	block_pkg::data_t chans [block_pkg::N_CH];
	block_pkg::data_t regs [block_pkg::N_REG];
	block_pkg::data_t targets [block_pkg::N_REG];
	logic [block_pkg::N_REG-1:0] pending;

	assign ch_out = chans;

	// Flag set picks the register bank
	assign opnd.val_a = opnd.rd_a_reg ? regs[opnd.rd_a] : chans[opnd.rd_a];
	assign opnd.val_b = opnd.rd_b_reg ? regs[opnd.rd_b] : chans[opnd.rd_b];
	assign opnd.val_c = opnd.rd_c_reg ? regs[opnd.rd_c] : chans[opnd.rd_c];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < block_pkg::N_CH; i++) begin
				chans[i] <= '0;
			end
			for (int i = 0; i < block_pkg::N_REG; i++) begin
				regs[i] <= '0;
				targets[i] <= '0;
			end
			pending <= '0;
		end else begin
			if (opnd.wr_en) begin
				if (opnd.wr_reg) begin
					regs[opnd.wr_addr] <= opnd.wr_data;
				end else begin
					chans[opnd.wr_addr] <= opnd.wr_data;
				end
			end

			// New frame from the previous stage, smoothed registers step by one
			if (tick) begin
				for (int i = 0; i < block_pkg::N_CH; i++) begin
					chans[i] <= ch_in[i];
				end
				for (int i = 0; i < block_pkg::N_REG; i++) begin
					if (pending[i]) begin
						if (targets[i] < regs[i]) begin
							regs[i] <= regs[i] - block_pkg::data_t'(1);
						end else if (targets[i] > regs[i]) begin
							regs[i] <= regs[i] + block_pkg::data_t'(1);
						end else begin
							pending[i] <= 1'b0;
						end
					end
				end
			end

			// Host access comes last and wins
			if (reg_write) begin
				regs[reg_target] <= reg_val;
			end else if (reg_update) begin
				targets[reg_target] <= reg_val;
				pending[reg_target] <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* design/pipeline_block.sv */
`default_nettype none

module pipeline_block (
	input  logic              clk,
	input  logic              reset,
	input  logic              tick,
	input  block_pkg::data_t  ch_in [block_pkg::N_CH],
	input  block_pkg::instr_t instr_val,
	input  logic              instr_write,
	input  block_pkg::data_t  reg_val,
	input  block_pkg::addr_t  reg_target,
	input  logic              reg_write,
	input  logic              reg_update,
	output block_pkg::data_t  ch_out [block_pkg::N_CH],
	output logic              done
);

	operand_if opnd_bus ();
	mul_if     mul_bus ();

	block_pkg::opcode_t alu_op;
	block_pkg::data_t   alu_a;
	block_pkg::data_t   alu_b;
	block_pkg::data_t   alu_result;

	block_control u_control (
		.clk         (clk),
		.reset       (reset),
		.tick        (tick),
		.instr_val   (instr_val),
		.instr_write (instr_write),
		.opnd        (opnd_bus.ctrl),
		.mul         (mul_bus.ctrl),
		.alu_op      (alu_op),
		.alu_a       (alu_a),
		.alu_b       (alu_b),
		.alu_result  (alu_result),
		.done        (done)
	);

	operand_file u_operands (
		.clk        (clk),
		.reset      (reset),
		.tick       (tick),
		.ch_in      (ch_in),
		.ch_out     (ch_out),
		.reg_val    (reg_val),
		.reg_target (reg_target),
		.reg_write  (reg_write),
		.reg_update (reg_update),
		.opnd       (opnd_bus.store)
	);

	block_alu u_alu (
		.op     (alu_op),
		.a      (alu_a),
		.b      (alu_b),
		.result (alu_result)
	);

	block_multiplier u_multiplier (
		.clk   (clk),
		.reset (reset),
		.mul   (mul_bus.unit)
	);

endmodule

`default_nettype wire

/* flist.f */
design/block_pkg.sv
design/block_ifs.sv
design/operand_file.sv
design/block_alu.sv
design/block_multiplier.sv
design/block_control.sv
design/pipeline_block.sv
verif/pipeline_block_properties.sv
verif/pipeline_block_tb.sv

/* verif/pipeline_block_properties.sv */
`default_nettype none

module pipeline_block_properties (
	input logic clk,
	input logic reset,
	input logic tick,
	input logic done
);
	timeunit 1ns;
	timeprecision 100ps;

	// Number of failed assertions so far
	int fail_count = 0;

	// Block comes out of reset idle
	done_after_reset: assert property (@(posedge clk) reset |=> done)
		else begin
			fail_count++;
			$error("done is low in the cycle after reset");
		end

	// Every tick starts an instruction
	done_low_after_tick: assert property (@(posedge clk) disable iff (reset) tick |=> !done)
		else begin
			fail_count++;
			$error("done is still high in the cycle after a tick");
		end

	// Only a tick clears done
	done_holds: assert property (@(posedge clk) disable iff (reset) (done && !tick) |=> done)
		else begin
			fail_count++;
			$error("done fell without a tick");
		end

endmodule

`default_nettype wire

/* verif/pipeline_block_tb.sv */
`default_nettype none

module pipeline_block_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 10;
	localparam int CYCLE_LIMIT = 300 * (block_pkg::DATA_W + 8) + RESET_CYCLES;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic tick = 1'b0;
	block_pkg::data_t ch_in [block_pkg::N_CH];
	block_pkg::instr_t instr_val = '0;
	logic instr_write = 1'b0;
	block_pkg::data_t reg_val = '0;
	block_pkg::addr_t reg_target = '0;
	logic reg_write = 1'b0;
	logic reg_update = 1'b0;
	block_pkg::data_t ch_out [block_pkg::N_CH];
	logic done;

	// Shadow state of the block
	block_pkg::data_t exp_ch [block_pkg::N_CH];
	block_pkg::data_t exp_reg [block_pkg::N_REG];
	block_pkg::data_t exp_tgt [block_pkg::N_REG];
	logic [block_pkg::N_REG-1:0] exp_pend = '0;
	block_pkg::data_t next_ch [block_pkg::N_CH];
	int exp_latency = 0;
	int wait_cycles = 0;
	int cycle_count = 0;
	event tick_sent;
	event check_done;

	pipeline_block UUT (
		.clk         (clk),
		.reset       (reset),
		.tick        (tick),
		.ch_in       (ch_in),
		.instr_val   (instr_val),
		.instr_write (instr_write),
		.reg_val     (reg_val),
		.reg_target  (reg_target),
		.reg_write   (reg_write),
		.reg_update  (reg_update),
		.ch_out      (ch_out),
		.done        (done)
	);

	bind pipeline_block pipeline_block_properties props (
		.clk   (clk),
		.reset (reset),
		.tick  (tick),
		.done  (done)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("Timeout: %0d cycles passed and the tests did not finish", cycle_count);
			$display("Done: errors found");
			$fatal(1, "timeout");
		end
	end

	task automatic check_value(input string name, input int got, input int expected);
		if (got != expected) begin
			$display("mismatch at %0t ns: %s is %0d, expected %0d", $time, name, got, expected);
			$display("Done: errors found");
			$fatal(1, "first error, run stopped");
		end
	endtask

	function automatic block_pkg::data_t clamp(input longint x);
		if (x > longint'(block_pkg::SAT_MAX)) return block_pkg::data_t'(block_pkg::SAT_MAX);
		if (x < longint'(block_pkg::SAT_MIN)) return block_pkg::data_t'(block_pkg::SAT_MIN);
		return block_pkg::data_t'(x);
	endfunction

	function automatic block_pkg::data_t read_operand(input logic is_reg, input logic [3:0] idx);
		return is_reg ? exp_reg[idx] : exp_ch[idx];
	endfunction

	// Kind bits are {dest, c, b, a}
	// A set bit selects a register
	function automatic block_pkg::instr_t encode(input logic [3:0] op, input logic [3:0] sa,
		input logic [3:0] sb, input logic [3:0] sc, input logic [3:0] dest,
		input logic [3:0] kind, input logic [3:0] shift);
		return {shift, kind, dest, sc, sb, sa, op};
	endfunction

	function automatic block_pkg::instr_t random_instr(input logic [3:0] op);
		return encode(op, 4'($urandom), 4'($urandom), 4'($urandom), 4'($urandom),
			4'($urandom), 4'($urandom));
	endfunction

	// Applies one tick and one instruction to the shadow state and returns cycles until done
	function automatic int model_tick(input block_pkg::instr_t ins);
		logic [3:0] op;
		logic [3:0] kind;
		block_pkg::data_t a;
		block_pkg::data_t b;
		block_pkg::data_t r;
		longint prod;
		logic writes;
		int lat;
		op = ins[3:0];
		kind = ins[block_pkg::KIND_LSB +: 4];
		for (int i = 0; i < block_pkg::N_CH; i++) begin
			exp_ch[i] = ch_in[i];
		end
		for (int i = 0; i < block_pkg::N_REG; i++) begin
			if (exp_pend[i]) begin
				if (exp_tgt[i] < exp_reg[i]) exp_reg[i] = exp_reg[i] - 16'sd1;
				else if (exp_tgt[i] > exp_reg[i]) exp_reg[i] = exp_reg[i] + 16'sd1;
				else exp_pend[i] = 1'b0;
			end
		end
		a = read_operand(kind[0], ins[block_pkg::SRC_A_LSB +: 4]);
		b = read_operand(kind[1], ins[block_pkg::SRC_B_LSB +: 4]);
		prod = (longint'(a) * longint'(b)) >>>
			(block_pkg::MUL_FRAC - int'(ins[block_pkg::PMS_LSB +: 4]));
		r = a;
		writes = 1'b1;
		lat = 1;
		case (op)
			4'd1: begin
				r = clamp(longint'(a) + longint'(b));
				lat = 2;
			end
			4'd2: begin
				r = clamp(longint'(a) - longint'(b));
				lat = 2;
			end
			4'd3: r = block_pkg::data_t'(longint'(a) * 2);
			4'd4: r = block_pkg::data_t'(longint'(a) >>> 1);
			4'd5: r = clamp((a < 0) ? -longint'(a) : longint'(a));
			4'd6: begin
				r = clamp(prod);
				lat = block_pkg::DATA_W + 3;
			end
			4'd7: begin
				b = read_operand(kind[2], ins[block_pkg::SRC_C_LSB +: 4]);
				r = clamp(longint'(clamp(prod)) + longint'(b));
				lat = block_pkg::DATA_W + 4;
			end
			default: writes = 1'b0;
		endcase
		if (writes && kind[3]) exp_reg[ins[block_pkg::DEST_LSB +: 4]] = r;
		else if (writes) exp_ch[ins[block_pkg::DEST_LSB +: 4]] = r;
		return lat;
	endfunction

	function automatic void fill_random();
		for (int i = 0; i < block_pkg::N_CH; i++) begin
			next_ch[i] = block_pkg::data_t'($urandom);
		end
	endfunction

	task automatic host_access(input logic smooth, input block_pkg::addr_t idx,
		input block_pkg::data_t val);
		@(posedge clk);
		#1;
		reg_target = idx;
		reg_val = val;
		reg_write = !smooth;
		reg_update = smooth;
		if (smooth) begin
			exp_tgt[idx] = val;
			exp_pend[idx] = 1'b1;
		end else begin
			exp_reg[idx] = val;
		end
		@(posedge clk);
		#1;
		reg_write = 1'b0;
		reg_update = 1'b0;
	endtask

	task automatic run_instr(input block_pkg::instr_t ins);
		@(posedge clk);
		#1;
		instr_val = ins;
		instr_write = 1'b1;
		@(posedge clk);
		#1;
		instr_write = 1'b0;
		ch_in = next_ch;
		tick = 1'b1;
		exp_latency = model_tick(ins);
		@(posedge clk);
		#1;
		tick = 1'b0;
		-> tick_sent;
		@(check_done);
	endtask

	// Waits for done after each tick and then compares latency and every channel
	always begin
		@(tick_sent);
		wait_cycles = 0;
		do begin
			@(posedge clk);
			wait_cycles++;
			@(negedge clk);
		end while (!done);
		check_value("done latency", wait_cycles, exp_latency);
		for (int i = 0; i < block_pkg::N_CH; i++) begin
			check_value($sformatf("ch_out[%0d]", i), int'(ch_out[i]), int'(exp_ch[i]));
		end
		-> check_done;
	end

	initial begin
		block_pkg::instr_t ins;
		block_pkg::instr_t abs_copy;
		void'($urandom(32'hcbbd));
		for (int i = 0; i < block_pkg::N_CH; i++) begin
			ch_in[i] = '0;
			exp_ch[i] = '0;
			next_ch[i] = '0;
		end
		for (int i = 0; i < block_pkg::N_REG; i++) begin
			exp_reg[i] = '0;
			exp_tgt[i] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
		@(negedge clk);
		check_value("done", int'(done), 1);
		for (int i = 0; i < block_pkg::N_CH; i++) begin
			check_value($sformatf("ch_out[%0d]", i), int'(ch_out[i]), 0);
		end

		fill_random();
		run_instr(encode(block_pkg::OP_NOP, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0));
		for (int i = 0; i < block_pkg::N_REG; i++) begin
			host_access(1'b0, 4'(i), block_pkg::data_t'($urandom));
		end

		repeat (60) begin
			fill_random();
			run_instr(random_instr(($urandom % 2 == 0) ? block_pkg::OP_ADD : block_pkg::OP_SUB));
		end
		// Saturation in both directions
		next_ch[0] = 16'sh7fff;
		next_ch[1] = 16'sd100;
		next_ch[2] = -16'sd30000;
		next_ch[3] = -16'sd10000;
		run_instr(encode(block_pkg::OP_ADD, 4'd0, 4'd1, 4'd0, 4'd4, 4'd0, 4'd0));
		run_instr(encode(block_pkg::OP_ADD, 4'd2, 4'd3, 4'd0, 4'd5, 4'd0, 4'd0));
		run_instr(encode(block_pkg::OP_SUB, 4'd0, 4'd3, 4'd0, 4'd6, 4'd0, 4'd0));
		run_instr(encode(block_pkg::OP_SUB, 4'd2, 4'd0, 4'd0, 4'd7, 4'd0, 4'd0));

		for (int k = 0; k < 2; k++) begin
			repeat (40) begin
				fill_random();
				ins = random_instr(($urandom % 2 == 0) ? block_pkg::OP_MUL : block_pkg::OP_MAC);
				ins[block_pkg::KIND_LSB + 3] = k[0];
				run_instr(ins);
			end
		end

		repeat (40) begin
			fill_random();
			run_instr(random_instr(4'(block_pkg::OP_LSH) + 4'($urandom % 3)));
		end
		next_ch[6] = 16'sh8000;
		run_instr(encode(block_pkg::OP_ABS, 4'd6, 4'd0, 4'd0, 4'd7, 4'd0, 4'd0));
		check_value("ch_out[7]", int'(ch_out[7]), 32767);

		// Register 5 ramps one step per tick and is copied to channel 0
		abs_copy = encode(block_pkg::OP_ABS, 4'd5, 4'd0, 4'd0, 4'd0, 4'b0001, 4'd0);
		host_access(1'b0, 4'd5, 16'sd100);
		host_access(1'b1, 4'd5, 16'sd104);
		for (int k = 1; k <= 6; k++) begin
			fill_random();
			run_instr(abs_copy);
			check_value("ch_out[0]", int'(ch_out[0]), (k <= 4) ? 100 + k : 104);
		end
		host_access(1'b1, 4'd5, 16'sd97);
		for (int k = 1; k <= 9; k++) begin
			fill_random();
			run_instr(abs_copy);
			check_value("ch_out[0]", int'(ch_out[0]), (k <= 7) ? 104 - k : 97);
		end
		host_access(1'b0, 4'd5, 16'sd2000);
		run_instr(abs_copy);
		check_value("ch_out[0]", int'(ch_out[0]), 2000);

		if (UUT.props.fail_count == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			$display("Done: errors found");
			$fatal(1, "%0d bound assertions failed during the run", UUT.props.fail_count);
		end
	end

endmodule

`default_nettype wire
